// ==== riscv_settings.svh ====
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// datapath widths
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define REG_COUNT       32   // x0 included
`define PC_WIDTH        16   // byte address into instruction memory

// on-chip memories, word organized
`define IMEM_DEPTH      256
`define DMEM_DEPTH      256
`define MEM_IDX_WIDTH   8    // word index into either memory

// loader port
`define WB_ADR_WIDTH    10   // top bit picks imem or dmem

`endif

// ==== riscv_isa_pkg.sv ====
`include "riscv_settings.svh"

package riscv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10   // link value for jal
    } result_src_e;

    // funct3 codes for register and immediate arithmetic
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // all zero means bubble
    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        mem_read;
        logic        branch;
        logic        jump;
        logic        alu_src;    // 1 selects immediate
        alu_op_e     alu_op;
        result_src_e result_src;
    } ctrl_t;

endpackage

// ==== riscv_pipe_pkg.sv ====
`include "riscv_settings.svh"

package riscv_pipe_pkg;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        logic                   valid;
        logic [`PC_WIDTH-1:0]   pc;
        logic [`PC_WIDTH-1:0]   pc_plus4;
        logic [`DATA_WIDTH-1:0] instr;
    } if_id_t;

    typedef struct packed {
        riscv_isa_pkg::ctrl_t       ctrl;
        logic [`PC_WIDTH-1:0]       pc;
        logic [`PC_WIDTH-1:0]       pc_plus4;
        logic [`DATA_WIDTH-1:0]     rs1_val;
        logic [`DATA_WIDTH-1:0]     rs2_val;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`DATA_WIDTH-1:0]     imm;
    } id_ex_t;

    typedef struct packed {
        riscv_isa_pkg::ctrl_t       ctrl;
        logic [`DATA_WIDTH-1:0]     alu_result;
        logic [`DATA_WIDTH-1:0]     write_data;   // store data after forwarding
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`PC_WIDTH-1:0]       pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic                       reg_write;
        riscv_isa_pkg::result_src_e result_src;
        logic [`DATA_WIDTH-1:0]     alu_result;
        logic [`DATA_WIDTH-1:0]     read_data;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`PC_WIDTH-1:0]       pc_plus4;
    } mem_wb_t;

    // core to data memory, no handshake
    typedef struct packed {
        logic                       we;
        logic [`MEM_IDX_WIDTH-1:0]  addr;   // word index
        logic [`DATA_WIDTH-1:0]     wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`WB_ADR_WIDTH-1:0] adr;
        logic [`DATA_WIDTH-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

endpackage

// ==== riscv_decoder.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"

module riscv_decoder import riscv_isa_pkg::*; (
    input  logic [`DATA_WIDTH-1:0]     instr_i,
    output ctrl_t                      ctrl_o,
    output logic [`DATA_WIDTH-1:0]     imm_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_o,
    output logic [`REG_ADDR_WIDTH-1:0] rd_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;   // instr bit 30
    alu_op_e    arith_op;

    assign opcode    = opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rs1_o     = instr_i[19:15];
    assign rs2_o     = instr_i[24:20];
    assign rd_o      = instr_i[11:7];

    // common to R and I arithmetic
    always_comb begin
        case (funct3)
            F3_SLT:  arith_op = ALU_SLT;
            F3_OR:   arith_op = ALU_OR;
            F3_AND:  arith_op = ALU_AND;
            default: arith_op = ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        case (opcode)
            OP_R: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = (funct3 == F3_ADD_SUB && funct7_b5) ? ALU_SUB : arith_op;
            end
            OP_I: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_op    = arith_op;
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            OP_LOAD: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.mem_read   = 1'b1;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = RES_MEM;
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            OP_STORE: begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OP_BRANCH: begin
                ctrl_o.branch = 1'b1;
                ctrl_o.alu_op = ALU_SUB;   // zero flag gives equality
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            OP_JAL: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.jump       = 1'b1;
                ctrl_o.result_src = RES_PC4;
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: ;   // unsupported, acts as bubble
        endcase
    end

endmodule

// ==== riscv_reg_file.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"

module riscv_reg_file (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic [`REG_ADDR_WIDTH-1:0] ra1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] ra2_i,
    input  logic [`REG_ADDR_WIDTH-1:0] wa_i,
    input  logic                       we_i,
    input  logic [`DATA_WIDTH-1:0]     wd_i,
    output logic [`DATA_WIDTH-1:0]     rd1_o,
    output logic [`DATA_WIDTH-1:0]     rd2_o
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];   // entry 0 never written

    // x0 reads zero, same-cycle write passes straight through
    function automatic logic [`DATA_WIDTH-1:0] read_reg(input logic [`REG_ADDR_WIDTH-1:0] ra);
        if (ra == '0) return '0;
        if (we_i && ra == wa_i) return wd_i;
        return regs[ra];
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    always_comb begin
        rd1_o = read_reg(ra1_i);
        rd2_o = read_reg(ra2_i);
    end

endmodule

// ==== riscv_alu.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"

module riscv_alu import riscv_isa_pkg::*; (
    input  logic [`DATA_WIDTH-1:0] a_i,
    input  logic [`DATA_WIDTH-1:0] b_i,
    input  alu_op_e                op_i,
    output logic [`DATA_WIDTH-1:0] result_o,
    output logic                   zero_o
);

    logic lt;   // signed compare

    assign lt = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {{(`DATA_WIDTH-1){1'b0}}, lt};
            default: result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);   // beq taken when set

endmodule

// ==== riscv_hazard_unit.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"

module riscv_hazard_unit import riscv_pipe_pkg::*; (
    input  logic [`REG_ADDR_WIDTH-1:0] id_rs1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] id_rs2_i,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rs1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rs2_i,
    input  logic                       ex_mem_read_i,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rd_i,
    input  logic [`REG_ADDR_WIDTH-1:0] mem_rd_i,
    input  logic                       mem_reg_write_i,
    input  logic [`REG_ADDR_WIDTH-1:0] wb_rd_i,
    input  logic                       wb_reg_write_i,
    input  logic                       redirect_i,
    output fwd_sel_e                   fwd_a_o,
    output fwd_sel_e                   fwd_b_o,
    output logic                       stall_o,
    output logic                       flush_o
);

    // youngest producer wins, x0 is never a source
    function automatic fwd_sel_e pick(input logic [`REG_ADDR_WIDTH-1:0] rs);
        if (mem_reg_write_i && mem_rd_i != '0 && mem_rd_i == rs) return FWD_MEM;
        if (wb_reg_write_i && wb_rd_i != '0 && wb_rd_i == rs) return FWD_WB;
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a_o = pick(ex_rs1_i);
        fwd_b_o = pick(ex_rs2_i);
    end

    // load in execute feeding the instruction in decode
    assign stall_o = ex_mem_read_i && ex_rd_i != '0 &&
                     (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

    assign flush_o = redirect_i;   // kill the two younger instructions

endmodule

// ==== riscv_core.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"

module riscv_core import riscv_isa_pkg::*, riscv_pipe_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   run_i,
    output logic [`PC_WIDTH-1:0]   imem_addr_o,
    input  logic [`DATA_WIDTH-1:0] imem_data_i,
    output dmem_req_t              dmem_req_o,
    input  logic [`DATA_WIDTH-1:0] dmem_data_i
);

    logic [`PC_WIDTH-1:0] pc_q;
    logic [`PC_WIDTH-1:0] pc_plus4;
    logic [`PC_WIDTH-1:0] target;
    if_id_t  if_id_q, if_id_d;
    id_ex_t  id_ex_q, id_ex_d;
    ex_mem_t ex_mem_q, ex_mem_d;
    mem_wb_t mem_wb_q, mem_wb_d;

    ctrl_t                      dec_ctrl;
    ctrl_t                      id_ctrl;
    logic [`DATA_WIDTH-1:0]     id_imm, id_rd1, id_rd2;
    logic [`REG_ADDR_WIDTH-1:0] id_rs1, id_rs2, id_rd;

    fwd_sel_e               fwd_a, fwd_b;
    logic [`DATA_WIDTH-1:0] mem_fwd, src_a, rs2_fwd, src_b, alu_result;
    logic                   alu_zero, redirect, stall, flush;
    logic [`DATA_WIDTH-1:0] wb_result;

    function automatic logic [`DATA_WIDTH-1:0] pc_to_word(input logic [`PC_WIDTH-1:0] pc);
        return {{(`DATA_WIDTH-`PC_WIDTH){1'b0}}, pc};
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] fwd_mux(input fwd_sel_e sel,
            input logic [`DATA_WIDTH-1:0] reg_val, mem_val, wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // fetch
    assign imem_addr_o = pc_q;
    assign pc_plus4    = pc_q + `PC_WIDTH'(4);
    assign if_id_d     = '{valid: 1'b1, pc: pc_q, pc_plus4: pc_plus4, instr: imem_data_i};

    // decode
    riscv_decoder i_decoder (
        .instr_i (if_id_q.instr),
        .ctrl_o  (dec_ctrl),
        .imm_o   (id_imm),
        .rs1_o   (id_rs1),
        .rs2_o   (id_rs2),
        .rd_o    (id_rd)
    );

    riscv_reg_file i_reg_file (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .ra1_i    (id_rs1),
        .ra2_i    (id_rs2),
        .wa_i     (mem_wb_q.rd),
        .we_i     (mem_wb_q.reg_write & run_i),
        .wd_i     (wb_result),
        .rd1_o    (id_rd1),
        .rd2_o    (id_rd2)
    );

    assign id_ctrl = if_id_q.valid ? dec_ctrl : '0;
    assign id_ex_d = '{ctrl: id_ctrl, pc: if_id_q.pc, pc_plus4: if_id_q.pc_plus4,
                       rs1_val: id_rd1, rs2_val: id_rd2, rs1: id_rs1, rs2: id_rs2,
                       rd: id_rd, imm: id_imm};

    // execute
    assign mem_fwd = (ex_mem_q.ctrl.result_src == RES_PC4) ?
                     pc_to_word(ex_mem_q.pc_plus4) : ex_mem_q.alu_result;

    always_comb begin
        src_a   = fwd_mux(fwd_a, id_ex_q.rs1_val, mem_fwd, wb_result);
        rs2_fwd = fwd_mux(fwd_b, id_ex_q.rs2_val, mem_fwd, wb_result);
        src_b   = id_ex_q.ctrl.alu_src ? id_ex_q.imm : rs2_fwd;
    end

    riscv_alu i_alu (
        .a_i      (src_a),
        .b_i      (src_b),
        .op_i     (id_ex_q.ctrl.alu_op),
        .result_o (alu_result),
        .zero_o   (alu_zero)
    );

    assign target   = id_ex_q.pc + id_ex_q.imm[`PC_WIDTH-1:0];
    assign redirect = id_ex_q.ctrl.jump | (id_ex_q.ctrl.branch & alu_zero);
    assign ex_mem_d = '{ctrl: id_ex_q.ctrl, alu_result: alu_result, write_data: rs2_fwd,
                        rd: id_ex_q.rd, pc_plus4: id_ex_q.pc_plus4};

    riscv_hazard_unit i_hazard_unit (
        .id_rs1_i        (id_rs1),
        .id_rs2_i        (id_rs2),
        .ex_rs1_i        (id_ex_q.rs1),
        .ex_rs2_i        (id_ex_q.rs2),
        .ex_mem_read_i   (id_ex_q.ctrl.mem_read),
        .ex_rd_i         (id_ex_q.rd),
        .mem_rd_i        (ex_mem_q.rd),
        .mem_reg_write_i (ex_mem_q.ctrl.reg_write),
        .wb_rd_i         (mem_wb_q.rd),
        .wb_reg_write_i  (mem_wb_q.reg_write),
        .redirect_i      (redirect),
        .fwd_a_o         (fwd_a),
        .fwd_b_o         (fwd_b),
        .stall_o         (stall),
        .flush_o         (flush)
    );

    // memory, store lands on the next edge
    assign dmem_req_o = '{we: ex_mem_q.ctrl.mem_write & run_i,
                          addr: ex_mem_q.alu_result[`MEM_IDX_WIDTH+1:2],
                          wdata: ex_mem_q.write_data};
    assign mem_wb_d   = '{reg_write: ex_mem_q.ctrl.reg_write,
                          result_src: ex_mem_q.ctrl.result_src,
                          alu_result: ex_mem_q.alu_result, read_data: dmem_data_i,
                          rd: ex_mem_q.rd, pc_plus4: ex_mem_q.pc_plus4};

    // writeback
    always_comb begin
        case (mem_wb_q.result_src)
            RES_MEM: wb_result = mem_wb_q.read_data;
            RES_PC4: wb_result = pc_to_word(mem_wb_q.pc_plus4);
            default: wb_result = mem_wb_q.alu_result;
        endcase
    end

    // pc and stage registers, frozen while run_i is low
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q     <= '0;
            if_id_q  <= '0;
            id_ex_q  <= '0;
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else if (run_i) begin
            if (redirect) pc_q <= target;
            else if (!stall) pc_q <= pc_plus4;

            if (flush) if_id_q.valid <= 1'b0;   // decode turns it into a bubble
            else if (!stall) if_id_q <= if_id_d;

            id_ex_q  <= (flush || stall) ? '0 : id_ex_d;   // bubble on either
            ex_mem_q <= ex_mem_d;
            mem_wb_q <= mem_wb_d;
        end
    end

endmodule

// ==== riscv_soc.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"

module riscv_soc import riscv_pipe_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    run_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    logic [`DATA_WIDTH-1:0] imem [`IMEM_DEPTH];
    logic [`DATA_WIDTH-1:0] dmem [`DMEM_DEPTH];

    logic [`PC_WIDTH-1:0]      imem_addr;
    logic [`DATA_WIDTH-1:0]    imem_data;
    logic [`DATA_WIDTH-1:0]    dmem_data;
    dmem_req_t                 dmem_req;

    logic                      wb_hit, wb_wr, wb_sel_dmem;
    logic [`MEM_IDX_WIDTH-1:0] wb_idx;
    logic [`DATA_WIDTH-1:0]    wb_rd_word;
    logic                      ack_q;
    logic [`DATA_WIDTH-1:0]    rd_dat_q;

    riscv_core i_riscv_core (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .run_i       (run_i),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .dmem_req_o  (dmem_req),
        .dmem_data_i (dmem_data)
    );

    assign imem_data = imem[imem_addr[`MEM_IDX_WIDTH+1:2]];
    assign dmem_data = dmem[dmem_req.addr];

    // new request only, the ack cycle still sees stb high
    assign wb_hit      = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wb_wr       = wb_hit & wb_req_i.we & ~run_i;
    assign wb_sel_dmem = wb_req_i.adr[`WB_ADR_WIDTH-1];
    assign wb_idx      = wb_req_i.adr[`MEM_IDX_WIDTH-1:0];
    assign wb_rd_word  = wb_sel_dmem ? dmem[wb_idx] : imem[wb_idx];

    always_ff @(posedge clk_i) begin
        if (wb_wr && !wb_sel_dmem) imem[wb_idx] <= wb_req_i.dat;
        if (dmem_req.we) dmem[dmem_req.addr] <= dmem_req.wdata;   // only while running
        else if (wb_wr && wb_sel_dmem) dmem[wb_idx] <= wb_req_i.dat;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) ack_q <= 1'b0;
        else ack_q <= wb_hit;   // single-cycle pulse
    end

    always_ff @(posedge clk_i) begin
        if (wb_hit) rd_dat_q <= run_i ? '0 : wb_rd_word;
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rd_dat_q};

endmodule

// ==== riscv_assert.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"

module riscv_assert (
    input logic                   clk_i,
    input logic                   arst_n_i,
    input logic                   run_i,
    input logic                   stb_i,
    input logic                   ack_i,
    input logic                   dmem_wb_wr_i,   // loader write into dmem
    input logic [`DATA_WIDTH-1:0] dmem_word_i,    // word at the core's data address
    input logic [`PC_WIDTH-1:0]   pc_i
);

    int unsigned fail_count = 0;   // failed assertions so far

    ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i) ack_i |=> !ack_i)
        else begin
            fail_count = fail_count + 1;
            $error("wishbone ack held for two cycles");
        end

    // ack only answers a strobe
    ack_after_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ack_i |-> $past(stb_i))
        else begin
            fail_count = fail_count + 1;
            $error("wishbone ack without a strobe in the cycle before");
        end

    // halted core leaves its data word alone
    core_store_running: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !run_i && !dmem_wb_wr_i |=> dmem_word_i === $past(dmem_word_i))
        else begin
            fail_count = fail_count + 1;
            $error("data memory changed by the core while halted");
        end

    pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pc_i[1:0] == 2'b00)
        else begin
            fail_count = fail_count + 1;
            $error("pc not word aligned");
        end

endmodule

bind riscv_soc riscv_assert i_riscv_assert (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .run_i        (run_i),
    .stb_i        (wb_req_i.stb),
    .ack_i        (wb_rsp_o.ack),
    .dmem_wb_wr_i (wb_wr & wb_sel_dmem),
    .dmem_word_i  (dmem_data),
    .pc_i         (imem_addr)
);

// ==== riscv_tb.sv ====
`timescale 1ns/100ps
`include "riscv_settings.svh"

module riscv_tb import riscv_pipe_pkg::*; ();

    localparam int RESET_CYCLES = 3;
    localparam int CYCLE_MARGIN = 50;
    localparam int BUS_CYCLES   = 8;   // budget per L or C command

    logic    clk;
    logic    arst_n;
    logic    run;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    // one entry per command from the cases file
    byte                    cmd_q[$];
    int unsigned            arg_a_q[$];
    logic [`DATA_WIDTH-1:0] arg_b_q[$];

    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;

    riscv_soc i_riscv_soc (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .run_i    (run),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // watchdog sized from the cases file
    always @(posedge clk) begin
        if (i_riscv_soc.i_riscv_assert.fail_count != 0) begin
            $display("a concurrent assertion in riscv_assert failed");
            $display("Test failures found");
            $fatal(1, "assertion failure");
        end else if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Test failures found");
            $fatal(1, "watchdog expired");
        end else begin
            cycles = cycles + 1;
        end
    end

    task automatic check_value(input string name, input logic [`DATA_WIDTH-1:0] got,
                               input logic [`DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "value mismatch");
        end
    endtask

    // one classic cycle, request held until ack
    task automatic bus_transfer(input logic we, input logic [`WB_ADR_WIDTH-1:0] adr,
                                input logic [`DATA_WIDTH-1:0] dat_w,
                                output logic [`DATA_WIDTH-1:0] dat_r);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat_w};
        @(negedge clk);
        while (!wb_rsp.ack) @(negedge clk);
        dat_r = wb_rsp.dat;   // sampled mid-cycle
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic run_cycles(input int unsigned n);
        @(posedge clk);
        run <= 1'b1;
        repeat (n) @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic read_cases();
        int                     fd;
        int                     fields;
        string                  line;
        string                  rest;
        byte                    kind;
        int unsigned            a;
        logic [`DATA_WIDTH-1:0] b;
        fd = $fopen("riscv_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open riscv_cases.txt");
            $display("Test failures found");
            $fatal(1, "no stimulus");
        end
        cycle_limit = RESET_CYCLES + CYCLE_MARGIN;
        while ($fgets(line, fd) > 0) begin
            kind = line.getc(0);
            if (kind == "R" || kind == "L" || kind == "C") begin
                rest = line.substr(1, line.len() - 1);
                b = '0;
                if (kind == "R") begin
                    fields = $sscanf(rest, "%d", a) + 1;   // run length in cycles
                    cycle_limit += a;
                end else begin
                    fields = $sscanf(rest, "%h %h", a, b);
                    cycle_limit += BUS_CYCLES;
                end
                if (fields != 2) begin
                    $display("malformed line in cases file: %s", line);
                    $display("Test failures found");
                    $fatal(1, "bad stimulus");
                end
                cmd_q.push_back(kind);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic [`DATA_WIDTH-1:0] rdata;
        arst_n <= 1'b0;
        run    <= 1'b0;
        wb_req <= '0;
        read_cases();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "L": bus_transfer(1'b1, `WB_ADR_WIDTH'(arg_a_q[i]), arg_b_q[i], rdata);
                "R": run_cycles(arg_a_q[i]);
                default: begin
                    bus_transfer(1'b0, `WB_ADR_WIDTH'(arg_a_q[i]), '0, rdata);
                    check_value($sformatf("wb_rsp_o.dat at adr %h", arg_a_q[i]),
                                rdata, arg_b_q[i]);
                end
            endcase
        end
        @(negedge clk);   // let the last edge's assertions settle
        if (i_riscv_soc.i_riscv_assert.fail_count != 0) begin
            $display("a concurrent assertion in riscv_assert failed");
            $display("Test failures found");
            $fatal(1, "assertion failure");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== riscv_cases.txt ====
# L adr word : wishbone write, adr bit 9 picks dmem, R n : run n cycles (decimal)
# C adr word : wishbone read and compare, adr and words in hex
L 000 01900093
L 001 FFA00113
L 002 002081B3
L 003 40208233
L 004 0020F2B3
L 005 0020E333
L 006 001123B3
L 007 0020A433
L 008 00302223
L 009 00402423
L 00A 00502623
L 00B 00602823
L 00C 00702A23
L 00D 00802C23
L 00E 00202E23
L 00F 00300493
L 010 00548493
L 011 00948533
L 012 00950533
L 013 02A02023
L 014 00002583
L 015 00158633
L 016 02C02223
L 017 00108663
L 018 02102423
L 019 02102623
L 01A 00208463
L 01B 02102823
L 01C 00C006EF
L 01D 02102A23
L 01E 02102C23
L 01F 02D02E23
L 020 06300013
L 021 04002023
L 022 0000006F
# data memory preloads
L 200 00001000
L 206 BAD00006
L 20A BAD0000A
L 20B BAD0000B
L 20C BAD0000C
L 20D BAD0000D
L 20E BAD0000E
L 210 BAD00010
R 80
# readback of program and load source
C 000 01900093
C 022 0000006F
C 200 00001000
# alu results
C 201 00000013
C 202 0000001F
C 203 00000018
C 204 FFFFFFFB
C 205 00000001
C 206 00000000
C 207 FFFFFFFA
# forwarding chain and load-use
C 208 00000018
C 209 00001019
# branches and jal
C 20A BAD0000A
C 20B BAD0000B
C 20C 00000019
C 20D BAD0000D
C 20E BAD0000E
C 20F 00000074
# x0 stays zero
C 210 00000000

// ==== all.f ====
+incdir+.
riscv_isa_pkg.sv
riscv_pipe_pkg.sv
riscv_decoder.sv
riscv_reg_file.sv
riscv_alu.sv
riscv_hazard_unit.sv
riscv_core.sv
riscv_soc.sv
riscv_assert.sv
riscv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module riscv_tb -f all.f -o riscv_sim \
    && { ./obj_dir/riscv_sim > sim.log 2>&1; cat sim.log; } \
    && ! grep -q 'Test failures found' sim.log \
    && grep -q 'All tests passed!' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
